/* source/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

  localparam int unsigned XLEN        = 32;
  localparam int unsigned FETCH_SLOTS = 2;
  localparam int unsigned FIFO_DEPTH  = 8;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // major opcode field in the instruction word
  localparam int unsigned OPC_MSB = 31;
  localparam int unsigned OPC_LSB = 28;

  typedef enum logic [3:0] {
    OP_ALU    = 4'h0,
    OP_LOAD   = 4'h1,
    OP_STORE  = 4'h2,
    OP_BRANCH = 4'h4,
    OP_JUMP   = 4'h5
  } major_op_e;

  typedef enum logic [2:0] {
    CLASS_ALU     = 3'd0,
    CLASS_LOAD    = 3'd1,
    CLASS_STORE   = 3'd2,
    CLASS_BRANCH  = 3'd3,
    CLASS_JUMP    = 3'd4,
    CLASS_ILLEGAL = 3'd5
  } op_class_e;

  typedef struct packed {
    logic            redirect;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [FETCH_SLOTS-1:0] mask;
  } fetch_req_t;

  // inst[0] is always the first valid slot
  typedef struct packed {
    logic [XLEN-1:0]                  pc;
    logic [FETCH_SLOTS-1:0][XLEN-1:0] inst;
    logic [FETCH_SLOTS-1:0]           mask;
  } fetch_grp_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    op_class_e       op_class;
    logic            illegal;
    logic [XLEN-1:0] inst;
  } issue_pkg_t;

  typedef struct packed {
    issue_pkg_t [FETCH_SLOTS-1:0] pkg;
    logic [FETCH_SLOTS-1:0]       mask;
  } issue_grp_t;

endpackage

`default_nettype wire

/* source/fetch_pc_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen (
  input  logic                     clk,
  input  logic                     rst_n,
  input  frontend_pkg::redirect_t  redirect_i,
  input  logic                     ready_i,
  output logic                     valid_o,
  output frontend_pkg::fetch_req_t req_o
);

  import frontend_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            valid_q;
  logic [XLEN-1:0] next_pc;

  // fall-through to the next aligned group
  assign next_pc = {pc_q[XLEN-1:3] + 1'b1, 3'b000};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b1;
      if (redirect_i.redirect)
        pc_q <= redirect_i.target;
      else if (valid_q && ready_i)
        pc_q <= next_pc;
    end
  end

  assign valid_o    = valid_q;
  assign req_o.pc   = pc_q;
  // upper half only when entering at slot 1
  assign req_o.mask = pc_q[2] ? 2'b10 : 2'b11;

endmodule

`default_nettype wire

/* source/stage_skid_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_skid_buffer #(
  parameter type data_t = logic
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  logic  ready_q;
  data_t hold_q;

  // ready low means hold_q carries an item
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      ready_q <= 1'b1;
    else
      ready_q <= !(valid_o && !ready_i);
  end

  always_ff @(posedge clk)
  begin
    if (ready_q)
      hold_q <= data_i;
  end

  assign ready_o = ready_q;
  assign valid_o = valid_i || !ready_q;
  assign data_o  = ready_q ? data_i : hold_q;

endmodule

`default_nettype wire

/* source/inst_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_fetch (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      flush_i,
  input  logic                                                      valid_i,
  output logic                                                      ready_o,
  input  frontend_pkg::fetch_req_t                                  req_i,
  output logic                                                      imem_req_o,
  output logic [frontend_pkg::XLEN-4:0]                             imem_addr_o,
  input  logic [frontend_pkg::FETCH_SLOTS-1:0][frontend_pkg::XLEN-1:0] imem_rdata_i,
  output logic                                                      valid_o,
  input  logic                                                      ready_i,
  output frontend_pkg::fetch_grp_t                                  grp_o
);

  import frontend_pkg::*;

  logic       pend_valid_q;
  fetch_req_t pend_q;
  fetch_grp_t cap_grp;
  fetch_grp_t hold_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] hold_cnt_q;
  logic [1:0] in_flight;
  logic       accept;
  logic       pop;

  assign pop       = valid_o && ready_i;
  assign in_flight = hold_cnt_q + {1'b0, pend_valid_q};
  // a group leaving this cycle frees its place
  assign ready_o   = (in_flight - {1'b0, pop}) < 2'd2;
  assign accept    = valid_i && ready_o && !flush_i;

  assign imem_req_o  = accept;
  assign imem_addr_o = req_i.pc[XLEN-1:3];

  // slot compaction for groups entered at slot 1
  always_comb
  begin
    cap_grp.pc   = pend_q.pc;
    cap_grp.inst = imem_rdata_i;
    cap_grp.mask = pend_q.mask;
    if (!pend_q.mask[0])
    begin
      cap_grp.inst[0] = imem_rdata_i[1];
      cap_grp.mask    = {1'b0, pend_q.mask[1]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      pend_valid_q <= 1'b0;
      wr_ptr_q     <= 1'b0;
      rd_ptr_q     <= 1'b0;
      hold_cnt_q   <= 2'd0;
    end
    else
    begin
      pend_valid_q <= accept;
      if (pend_valid_q)
        wr_ptr_q <= !wr_ptr_q;
      if (pop)
        rd_ptr_q <= !rd_ptr_q;
      hold_cnt_q <= hold_cnt_q + {1'b0, pend_valid_q} - {1'b0, pop};
    end
  end

  // response arrives the cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (accept)
      pend_q <= req_i;
    if (pend_valid_q)
      hold_q[wr_ptr_q] <= cap_grp;
  end

  assign valid_o = hold_cnt_q != 2'd0;
  assign grp_o   = hold_q[rd_ptr_q];

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
  input  logic [frontend_pkg::XLEN-1:0] inst_i,
  output frontend_pkg::op_class_e       class_o,
  output logic                          illegal_o
);

  import frontend_pkg::*;

  major_op_e major_op;

  assign major_op = major_op_e'(inst_i[OPC_MSB:OPC_LSB]);

  always_comb
  begin
    case (major_op)
      OP_ALU:
        class_o = CLASS_ALU;
      OP_LOAD:
        class_o = CLASS_LOAD;
      OP_STORE:
        class_o = CLASS_STORE;
      OP_BRANCH:
        class_o = CLASS_BRANCH;
      OP_JUMP:
        class_o = CLASS_JUMP;
      // 3 and 6..15 are unassigned
      default:
        class_o = CLASS_ILLEGAL;
    endcase
  end

  assign illegal_o = (class_o == CLASS_ILLEGAL);

endmodule

`default_nettype wire

/* source/issue_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_fifo #(
  parameter int unsigned DEPTH = frontend_pkg::FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  input  frontend_pkg::issue_grp_t data_i,
  output logic                     valid_o,
  input  logic                     ready_i,
  output frontend_pkg::issue_grp_t data_o
);

  import frontend_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  issue_grp_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = count_q != CNT_W'(DEPTH);
  assign valid_o = count_q != '0;
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* source/frontend_top.sv */
`timescale 1ns/100ps
`default_nettype none

module frontend_top (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  frontend_pkg::redirect_t                                   redirect_i,
  output logic                                                      imem_req_o,
  output logic [frontend_pkg::XLEN-4:0]                             imem_addr_o,
  input  logic [frontend_pkg::FETCH_SLOTS-1:0][frontend_pkg::XLEN-1:0] imem_rdata_i,
  output logic                                                      pkg_valid_o,
  input  logic                                                      pkg_ready_i,
  output logic [frontend_pkg::FETCH_SLOTS-1:0]                      pkg_mask_o,
  output frontend_pkg::issue_pkg_t [frontend_pkg::FETCH_SLOTS-1:0]  pkg_o
);

  import frontend_pkg::*;

  logic       flush;
  logic       pcg_valid;
  logic       pcg_ready;
  fetch_req_t pcg_req;
  logic       f_in_valid;
  logic       f_in_ready;
  fetch_req_t f_in_req;
  logic       f_out_valid;
  logic       f_out_ready;
  fetch_grp_t f_out_grp;
  logic       d_in_valid;
  logic       d_in_ready;
  fetch_grp_t d_in_grp;
  logic       d_valid_q;
  fetch_grp_t d_q;
  issue_grp_t d_out;
  logic       d_out_ready;
  logic       q_in_valid;
  logic       q_in_ready;
  issue_grp_t q_in_grp;
  issue_grp_t q_out;
  op_class_e  slot_class [FETCH_SLOTS];
  logic       slot_illegal [FETCH_SLOTS];

  assign flush = redirect_i.redirect;

  fetch_pc_gen fetch_pc_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .redirect_i(redirect_i),
    .ready_i   (pcg_ready),
    .valid_o   (pcg_valid),
    .req_o     (pcg_req)
  );

  stage_skid_buffer #(.data_t(fetch_req_t)) pc_skid_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush_i(flush),
    .valid_i(pcg_valid),
    .ready_o(pcg_ready),
    .data_i (pcg_req),
    .valid_o(f_in_valid),
    .ready_i(f_in_ready),
    .data_o (f_in_req)
  );

  inst_fetch inst_fetch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .valid_i     (f_in_valid),
    .ready_o     (f_in_ready),
    .req_i       (f_in_req),
    .imem_req_o  (imem_req_o),
    .imem_addr_o (imem_addr_o),
    .imem_rdata_i(imem_rdata_i),
    .valid_o     (f_out_valid),
    .ready_i     (f_out_ready),
    .grp_o       (f_out_grp)
  );

  stage_skid_buffer #(.data_t(fetch_grp_t)) fetch_skid_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush_i(flush),
    .valid_i(f_out_valid),
    .ready_o(f_out_ready),
    .data_i (f_out_grp),
    .valid_o(d_in_valid),
    .ready_i(d_in_ready),
    .data_o (d_in_grp)
  );

  // decode register
  assign d_in_ready = !d_valid_q || d_out_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush)
      d_valid_q <= 1'b0;
    else if (d_in_ready)
      d_valid_q <= d_in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (d_in_ready && d_in_valid)
      d_q <= d_in_grp;
  end

  for (genvar i = 0; i < FETCH_SLOTS; i++)
  begin : gen_slot
    inst_decoder inst_decoder_i (
      .inst_i   (d_q.inst[i]),
      .class_o  (slot_class[i]),
      .illegal_o(slot_illegal[i])
    );
  end

  always_comb
  begin
    d_out.mask = d_q.mask;
    for (int i = 0; i < FETCH_SLOTS; i++)
    begin
      d_out.pkg[i].pc       = d_q.pc;
      d_out.pkg[i].op_class = slot_class[i];
      d_out.pkg[i].illegal  = slot_illegal[i];
      d_out.pkg[i].inst     = d_q.inst[i];
    end
    // upper word of the group
    d_out.pkg[1].pc[2] = 1'b1;
  end

  stage_skid_buffer #(.data_t(issue_grp_t)) dec_skid_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush_i(flush),
    .valid_i(d_valid_q),
    .ready_o(d_out_ready),
    .data_i (d_out),
    .valid_o(q_in_valid),
    .ready_i(q_in_ready),
    .data_o (q_in_grp)
  );

  issue_fifo #(.DEPTH(FIFO_DEPTH)) issue_fifo_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush_i(flush),
    .valid_i(q_in_valid),
    .ready_o(q_in_ready),
    .data_i (q_in_grp),
    .valid_o(pkg_valid_o),
    .ready_i(pkg_ready_i),
    .data_o (q_out)
  );

  assign pkg_o      = q_out.pkg;
  assign pkg_mask_o = q_out.mask;

endmodule

`default_nettype wire

/* bench/imem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module imem_model (
  input  logic                                                         clk,
  input  logic                                                         req_i,
  input  logic [frontend_pkg::XLEN-4:0]                                addr_i,
  output logic [frontend_pkg::FETCH_SLOTS-1:0][frontend_pkg::XLEN-1:0] rdata_o
);

  import frontend_pkg::*;

  // opcode nibble for (group address + slot) mod 8
  function automatic logic [3:0] class_nibble(input logic [2:0] idx);
    case (idx)
      3'd0:    class_nibble = 4'h0;
      3'd1:    class_nibble = 4'h1;
      3'd2:    class_nibble = 4'h2;
      3'd3:    class_nibble = 4'h4;
      3'd4:    class_nibble = 4'h5;
      3'd5:    class_nibble = 4'h3;
      3'd6:    class_nibble = 4'h0;
      default: class_nibble = 4'hc;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] word_at(input logic [XLEN-4:0] grp, input int unsigned slot);
    logic [XLEN-3:0] waddr;
    waddr   = {grp, slot[0]};
    // top word address bits folded into the low ones
    word_at = {class_nibble(grp[2:0] + 3'(slot)), waddr[27:0] ^ {26'd0, waddr[29:28]}};
  endfunction

  always_ff @(posedge clk)
  begin
    if (req_i)
    begin
      for (int j = 0; j < FETCH_SLOTS; j++)
        rdata_o[j] <= word_at(addr_i, j);
    end
  end

endmodule

`default_nettype wire

/* bench/frontend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module frontend_tb;

  import frontend_pkg::*;

  localparam int unsigned SEED        = 89938;
  localparam int unsigned NUM_STIM    = 8;
  localparam int unsigned WAIT_CYCLES = 200;

  typedef struct packed {
    logic            redirect;
    logic [XLEN-1:0] target;
    logic [7:0]      count;
    logic [7:0]      ready_pct;
  } stim_t;

  logic                                 clk;
  logic                                 rst_n;
  redirect_t                            redirect;
  logic                                 imem_req;
  logic [XLEN-4:0]                      imem_addr;
  logic [FETCH_SLOTS-1:0][XLEN-1:0]     imem_rdata;
  logic                                 pkg_valid;
  logic                                 pkg_ready;
  logic [FETCH_SLOTS-1:0]               pkg_mask;
  issue_pkg_t [FETCH_SLOTS-1:0]         pkg;

  stim_t           stim_table [NUM_STIM];
  logic [XLEN-1:0] model_pc;

  frontend_top frontend_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect_i  (redirect),
    .imem_req_o  (imem_req),
    .imem_addr_o (imem_addr),
    .imem_rdata_i(imem_rdata),
    .pkg_valid_o (pkg_valid),
    .pkg_ready_i (pkg_ready),
    .pkg_mask_o  (pkg_mask),
    .pkg_o       (pkg)
  );

  imem_model imem_model_i (
    .clk    (clk),
    .req_i  (imem_req),
    .addr_i (imem_addr),
    .rdata_o(imem_rdata)
  );

  initial
    clk = 1'b0;

  always #4 clk = ~clk;

  task automatic check_equal(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic logic [3:0] opcode_nibble(input logic [2:0] idx);
    case (idx)
      3'd0:    opcode_nibble = 4'h0;
      3'd1:    opcode_nibble = 4'h1;
      3'd2:    opcode_nibble = 4'h2;
      3'd3:    opcode_nibble = 4'h4;
      3'd4:    opcode_nibble = 4'h5;
      3'd5:    opcode_nibble = 4'h3;
      3'd6:    opcode_nibble = 4'h0;
      default: opcode_nibble = 4'hc;
    endcase
  endfunction

  // expected memory word for slot of group address grp
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-4:0] grp, input logic slot);
    logic [XLEN-3:0] word_addr;
    logic [3:0]      nibble;
    word_addr = {grp, slot};
    nibble    = opcode_nibble(grp[2:0] + {2'b00, slot});
    mem_word  = {nibble, word_addr[27:0] ^ {26'd0, word_addr[29:28]}};
  endfunction

  function automatic op_class_e class_of(input logic [3:0] nibble);
    case (nibble)
      4'h0:    class_of = CLASS_ALU;
      4'h1:    class_of = CLASS_LOAD;
      4'h2:    class_of = CLASS_STORE;
      4'h4:    class_of = CLASS_BRANCH;
      4'h5:    class_of = CLASS_JUMP;
      default: class_of = CLASS_ILLEGAL;
    endcase
  endfunction

  task automatic compare_slot(input int slot, input logic [XLEN-1:0] exp_pc,
                              input logic [XLEN-1:0] exp_inst);
    op_class_e exp_class;
    exp_class = class_of(exp_inst[31:28]);
    check_equal(pkg[slot].pc, exp_pc, $sformatf("slot %0d pc", slot));
    check_equal(pkg[slot].inst, exp_inst, $sformatf("slot %0d instruction", slot));
    check_equal(pkg[slot].op_class, exp_class, $sformatf("slot %0d op class", slot));
    check_equal(pkg[slot].illegal, exp_class == CLASS_ILLEGAL,
                $sformatf("slot %0d illegal flag", slot));
  endtask

  // compares the accepted package with the model, then steps the model pc
  task automatic inspect_package();
    logic [XLEN-4:0] grp;
    logic            entered_high;
    grp          = model_pc[XLEN-1:3];
    entered_high = model_pc[2];
    check_equal(pkg_mask, entered_high ? 2'b01 : 2'b11, "package mask");
    compare_slot(0, model_pc, mem_word(grp, entered_high));
    if (!entered_high)
      compare_slot(1, {grp, 3'b100}, mem_word(grp, 1'b1));
    model_pc = {grp, 3'b000} + XLEN'(8);
  endtask

  task automatic collect_packages(input int unsigned count, input int unsigned ready_pct);
    int unsigned got;
    int unsigned idle;
    got  = 0;
    idle = 0;
    while (got < count)
    begin
      @(posedge clk);
      #1;
      pkg_ready = ($urandom % 100) < ready_pct;
      @(negedge clk);
      if (pkg_valid && pkg_ready)
      begin
        inspect_package();
        got++;
        idle = 0;
      end
      else if (idle == WAIT_CYCLES)
      begin
        $display("Timeout: no package arrived within %0d cycles", WAIT_CYCLES);
        $display("Test failed");
        $fatal(1);
      end
      else
        idle++;
    end
  endtask

  // one-cycle pulse while the backend holds off
  task automatic send_redirect(input logic [XLEN-1:0] target);
    @(posedge clk);
    #1;
    pkg_ready         = 1'b0;
    redirect.redirect = 1'b1;
    redirect.target   = target;
    @(posedge clk);
    #1;
    redirect = '0;
    model_pc = target;
    @(negedge clk);
    check_equal(pkg_valid, 1'b0, "package valid after flush");
  endtask

  task automatic load_stim_table();
    // redirect, target, packages, ready percent
    stim_table[0] = {1'b0, RESET_PC, 8'd12, 8'd100};
    stim_table[1] = {1'b1, 32'h0000_2004, 8'd6, 8'd100};
    stim_table[2] = {1'b0, 32'h0000_0000, 8'd40, 8'd40};
    stim_table[3] = {1'b1, 32'h0001_0028, 8'd10, 8'd60};
    stim_table[4] = {1'b1, 32'h8000_003c, 8'd8, 8'd70};
    stim_table[5] = {1'b1, 32'h0000_0100, 8'd2, 8'd100};
    // wraps past the top of the address space
    stim_table[6] = {1'b1, 32'hffff_fff0, 8'd5, 8'd50};
    stim_table[7] = {1'b1, 32'h0000_3000, 8'd30, 8'd30};
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n        = 1'b0;
    redirect     = '0;
    pkg_ready    = 1'b0;
    model_pc     = RESET_PC;
    load_stim_table();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_equal(pkg_valid, 1'b0, "package valid after reset");
    check_equal(imem_req, 1'b0, "memory request after reset");
    for (int i = 0; i < NUM_STIM; i++)
    begin
      if (stim_table[i].redirect)
        send_redirect(stim_table[i].target);
      collect_packages(stim_table[i].count, stim_table[i].ready_pct);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/frontend_pkg.sv
source/fetch_pc_gen.sv
source/stage_skid_buffer.sv
source/inst_fetch.sv
source/inst_decoder.sv
source/issue_fifo.sv
source/frontend_top.sv
bench/imem_model.sv
bench/frontend_tb.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - source/frontend_pkg.sv
      - source/fetch_pc_gen.sv
      - source/stage_skid_buffer.sv
      - source/inst_fetch.sv
      - source/inst_decoder.sv
      - source/issue_fifo.sv
      - source/frontend_top.sv
  - target: test
    files:
      - bench/imem_model.sv
      - bench/frontend_tb.sv
